/* rtl/discardPkg.sv */
package discardPkg;

  // ------------------------------
  // Stream and channel sizes
  // ------------------------------

  // Logical channels sharing the input stream
  localparam int CHANNEL_COUNT = 4;
  // Width of a channel number
  localparam int CHANNEL_BITS = 2;
  // Width of one data word
  localparam int WORD_BITS = 32;
  // Width of the header length field
  localparam int LENGTH_BITS = 8;
  // Header bits between channel and length
  localparam int RESERVED_BITS = WORD_BITS - CHANNEL_BITS - LENGTH_BITS;

  // ------------------------------
  // Credits
  // ------------------------------

  // Credit counter width, must hold CREDIT_MAX
  localparam int CREDIT_BITS = 7;
  // Downstream buffer per channel in words, also the reset credit
  localparam logic [CREDIT_BITS-1:0] CREDIT_MAX = 7'd64;

  // ------------------------------
  // Statistics
  // ------------------------------

  // Width of a frame counter, wraps at full width
  localparam int COUNTER_BITS = 32;
  // Address is {channel, kind}
  localparam int STAT_ADDR_BITS = 3;
  // Kind codes in the address low bit
  localparam logic STAT_KIND_PASSED = 1'b0;
  localparam logic STAT_KIND_DROPPED = 1'b1;

  // One stream word, seen as payload or as a frame header
  typedef union packed {
    // Payload view
    logic [WORD_BITS-1:0] raw;
    // Header view of the first word of a frame
    struct packed {
      logic [CHANNEL_BITS-1:0]  channel;
      logic [RESERVED_BITS-1:0] reserved;
      // Frame length in words, header included
      logic [LENGTH_BITS-1:0]   length;
    } header;
  } frameWord;

endpackage

/* rtl/channelSplitter.sv */
`timescale 1ns/1ps

module channelSplitter (
  input  logic                                 CLK,
  input  logic                                 reset,
  // Shared input stream, never stalled
  input  discardPkg::frameWord                 inData,
  input  logic                                 inValid,
  input  logic                                 inSof,
  input  logic                                 inEof,
  // One-hot word strobe per discard unit
  output logic [discardPkg::CHANNEL_COUNT-1:0] chanValid,
  // Word and flags shared by all units
  output discardPkg::frameWord                 chanData,
  output logic                                 chanSof,
  output logic                                 chanEof
);

  // Channel of the frame in progress
  logic [discardPkg::CHANNEL_BITS-1:0] frameChannel;
  // Channel of the word on the input this cycle
  logic [discardPkg::CHANNEL_BITS-1:0] wordChannel;
  // Decoded strobe for that channel
  logic [discardPkg::CHANNEL_COUNT-1:0] channelOneHot;

  // ------------------------------
  // Channel tracking
  // ------------------------------

  // Header word carries its own channel, later words use the held one
  assign wordChannel = inSof ? inData.header.channel : frameChannel;

  always_ff @(posedge CLK) begin
    if (reset) begin
      frameChannel <= '0;
    end else if (inValid && inSof) begin
      // Held until the next header, so it covers the whole frame
      frameChannel <= inData.header.channel;
    end
  end

  // Units only see a strobe, never a channel number
  always_comb begin
    channelOneHot = '0;
    channelOneHot[wordChannel] = 1'b1;
  end

  // ------------------------------
  // Word register
  // ------------------------------

  always_ff @(posedge CLK) begin
    if (reset) begin
      chanValid <= '0;
    end else if (inValid) begin
      chanValid <= channelOneHot;
    end else begin
      // Idle cycle, no unit sees a word
      chanValid <= '0;
    end
  end

  // Payload and flags, qualified by chanValid downstream
  always_ff @(posedge CLK) begin
    chanData <= inData;
    chanSof  <= inSof;
    chanEof  <= inEof;
  end

endmodule

/* rtl/discardChannel.sv */
`timescale 1ns/1ps

module discardChannel (
  input  logic                                CLK,
  input  logic                                reset,
  // Word from the splitter, strobe is for this channel only
  input  logic                                wordValid,
  input  discardPkg::frameWord                wordData,
  input  logic                                wordSof,
  input  logic                                wordEof,
  // One word of downstream space given back
  input  logic                                creditReturn,
  // Words of kept frames towards the merger
  output logic                                passValid,
  output discardPkg::frameWord                passData,
  output logic                                passSof,
  output logic                                passEof,
  // Frame statistics, wrap at full width
  output logic [discardPkg::COUNTER_BITS-1:0] passedCount,
  output logic [discardPkg::COUNTER_BITS-1:0] droppedCount
);

  // Free downstream words for this channel
  logic [discardPkg::CREDIT_BITS-1:0] creditCount;
  // Return pulse as a counter increment
  logic [discardPkg::CREDIT_BITS-1:0] creditReturnWide;
  // Words reserved by a header passed this cycle
  logic [discardPkg::CREDIT_BITS-1:0] creditReserve;
  // Credits widened to the length field for the compare
  logic [discardPkg::LENGTH_BITS-1:0] creditCompare;
  // Header of a new frame present this cycle
  logic headerValid;
  // Header length fits in the free space
  logic frameFits;
  // Decision for the rest of the current frame
  logic keepFrame;
  // Word goes on to the merger
  logic forwardWord;

  // ------------------------------
  // Pass or drop decision
  // ------------------------------

  assign headerValid = wordValid && wordSof;

  // Registered credits only, so a return counts from the next cycle on
  assign creditCompare = {
    {(discardPkg::LENGTH_BITS - discardPkg::CREDIT_BITS){1'b0}},
    creditCount
  };

  // Frame passes only if every one of its words has room
  assign frameFits = creditCompare >= wordData.header.length;

  // Header word uses the fresh decision, later words the stored one
  assign forwardWord = wordValid && (wordSof ? frameFits : keepFrame);

  always_ff @(posedge CLK) begin
    if (reset) begin
      keepFrame <= 1'b0;
    end else if (headerValid) begin
      keepFrame <= frameFits;
    end
  end

  // ------------------------------
  // Credit counter
  // ------------------------------

  assign creditReturnWide = {{(discardPkg::CREDIT_BITS - 1){1'b0}}, creditReturn};

  // A passed length never exceeds the credits, so the low bits are enough
  assign creditReserve = (headerValid && frameFits)
                       ? wordData.header.length[discardPkg::CREDIT_BITS-1:0]
                       : '0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      // Downstream buffer starts empty
      creditCount <= discardPkg::CREDIT_MAX;
    end else begin
      // Return and reservation in one cycle both apply
      creditCount <= creditCount + creditReturnWide - creditReserve;
    end
  end

  // ------------------------------
  // Frame counters
  // ------------------------------

  // Counted on the decision cycle of the header
  always_ff @(posedge CLK) begin
    if (reset) begin
      passedCount  <= '0;
      droppedCount <= '0;
    end else if (headerValid) begin
      if (frameFits) begin
        passedCount <= passedCount + 1'b1;
      end else begin
        droppedCount <= droppedCount + 1'b1;
      end
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------

  always_ff @(posedge CLK) begin
    if (reset) begin
      passValid <= 1'b0;
    end else begin
      // Dropped words stop here
      passValid <= forwardWord;
    end
  end

  // Payload follows the strobe one stage later
  always_ff @(posedge CLK) begin
    passData <= wordData;
    passSof  <= wordSof;
    passEof  <= wordEof;
  end

endmodule

/* rtl/outputMerger.sv */
`timescale 1ns/1ps

module outputMerger (
  input  logic                                 CLK,
  input  logic                                 reset,
  // Per-channel streams, at most one valid per cycle
  input  logic [discardPkg::CHANNEL_COUNT-1:0] passValid,
  input  discardPkg::frameWord                 passData [discardPkg::CHANNEL_COUNT],
  input  logic [discardPkg::CHANNEL_COUNT-1:0] passSof,
  input  logic [discardPkg::CHANNEL_COUNT-1:0] passEof,
  // Tagged output stream
  output logic                                 outValid,
  output logic [discardPkg::CHANNEL_BITS-1:0]  outChannel,
  output discardPkg::frameWord                 outData,
  output logic                                 outSof,
  output logic                                 outEof
);

  // Number of the active channel
  logic [discardPkg::CHANNEL_BITS-1:0] selChannel;
  // Word of the active channel
  discardPkg::frameWord selData;
  // Flags of the active channel
  logic selSof;
  logic selEof;
  // Any channel has a word this cycle
  logic anyValid;

  // ------------------------------
  // Channel select
  // ------------------------------

  assign anyValid = |passValid;

  // Valid vector is one-hot, so OR-ing masked values is the select
  always_comb begin
    selChannel = '0;
    selData.raw = '0;
    for (int i = 0; i < discardPkg::CHANNEL_COUNT; i++) begin
      if (passValid[i]) begin
        // Encoder for the channel tag
        selChannel = selChannel | i[discardPkg::CHANNEL_BITS-1:0];
        selData.raw = selData.raw | passData[i].raw;
      end
    end
  end

  // Flags taken only from the valid channel
  assign selSof = |(passValid & passSof);
  assign selEof = |(passValid & passEof);

  // ------------------------------
  // Output register
  // ------------------------------

  always_ff @(posedge CLK) begin
    if (reset) begin
      outValid <= 1'b0;
    end else begin
      outValid <= anyValid;
    end
  end

  // Tag, word and flags ride along with outValid
  always_ff @(posedge CLK) begin
    outChannel <= selChannel;
    outData    <= selData;
    outSof     <= selSof;
    outEof     <= selEof;
  end

endmodule

/* rtl/statReader.sv */
`timescale 1ns/1ps

module statReader (
  input  logic                                 CLK,
  input  logic                                 reset,
  // Read strobe with the counter address
  input  logic                                 statRead,
  input  logic [discardPkg::STAT_ADDR_BITS-1:0] statAddr,
  // Counters of all channels
  input  logic [discardPkg::COUNTER_BITS-1:0]  passedCount [discardPkg::CHANNEL_COUNT],
  input  logic [discardPkg::COUNTER_BITS-1:0]  droppedCount [discardPkg::CHANNEL_COUNT],
  // Read data, one cycle after the strobe
  output logic                                 statValid,
  output logic [discardPkg::COUNTER_BITS-1:0]  statData
);

  // Channel part of the address
  logic [discardPkg::CHANNEL_BITS-1:0] readChannel;
  // Counter kind, passed or dropped
  logic readKind;
  // Counter picked by the address
  logic [discardPkg::COUNTER_BITS-1:0] readCounter;

  // ------------------------------
  // Address decode
  // ------------------------------

  // Upper bits are the channel, low bit the kind
  assign readChannel = statAddr[discardPkg::STAT_ADDR_BITS-1:1];
  assign readKind    = statAddr[0];

  always_comb begin
    if (readKind == discardPkg::STAT_KIND_DROPPED) begin
      readCounter = droppedCount[readChannel];
    end else begin
      readCounter = passedCount[readChannel];
    end
  end

  // ------------------------------
  // Read response
  // ------------------------------

  // One strobe per read, back-to-back reads give back-to-back strobes
  always_ff @(posedge CLK) begin
    if (reset) begin
      statValid <= 1'b0;
    end else begin
      statValid <= statRead;
    end
  end

  // Data held between reads
  always_ff @(posedge CLK) begin
    if (statRead) begin
      statData <= readCounter;
    end
  end

endmodule

/* rtl/discardStat.sv */
`timescale 1ns/1ps

module discardStat (
  input  logic                                  CLK,
  input  logic                                  reset,
  // Input stream, all channels interleaved by frame
  input  discardPkg::frameWord                  inData,
  input  logic                                  inValid,
  input  logic                                  inSof,
  input  logic                                  inEof,
  // Downstream space returned, one bit per channel
  input  logic [discardPkg::CHANNEL_COUNT-1:0]  creditReturn,
  // Output stream tagged with its channel
  output logic                                  outValid,
  output logic [discardPkg::CHANNEL_BITS-1:0]   outChannel,
  output discardPkg::frameWord                  outData,
  output logic                                  outSof,
  output logic                                  outEof,
  // Statistics read port
  input  logic                                  statRead,
  input  logic [discardPkg::STAT_ADDR_BITS-1:0] statAddr,
  output logic                                  statValid,
  output logic [discardPkg::COUNTER_BITS-1:0]   statData
);

  // Splitter to units
  logic [discardPkg::CHANNEL_COUNT-1:0] chanValid;
  discardPkg::frameWord chanData;
  logic chanSof;
  logic chanEof;

  // Units to merger
  logic [discardPkg::CHANNEL_COUNT-1:0] passValid;
  discardPkg::frameWord passData [discardPkg::CHANNEL_COUNT];
  logic [discardPkg::CHANNEL_COUNT-1:0] passSof;
  logic [discardPkg::CHANNEL_COUNT-1:0] passEof;

  // Units to statistics reader
  logic [discardPkg::COUNTER_BITS-1:0] passedCount [discardPkg::CHANNEL_COUNT];
  logic [discardPkg::COUNTER_BITS-1:0] droppedCount [discardPkg::CHANNEL_COUNT];

  // Word register and channel steering
  channelSplitter splitter (
    .CLK       (CLK),
    .reset     (reset),
    .inData    (inData),
    .inValid   (inValid),
    .inSof     (inSof),
    .inEof     (inEof),
    .chanValid (chanValid),
    .chanData  (chanData),
    .chanSof   (chanSof),
    .chanEof   (chanEof)
  );

  // One discard unit per channel
  for (genvar ch = 0; ch < discardPkg::CHANNEL_COUNT; ch++) begin : genChannel
    discardChannel channelUnit (
      .CLK          (CLK),
      .reset        (reset),
      .wordValid    (chanValid[ch]),
      .wordData     (chanData),
      .wordSof      (chanSof),
      .wordEof      (chanEof),
      .creditReturn (creditReturn[ch]),
      .passValid    (passValid[ch]),
      .passData     (passData[ch]),
      .passSof      (passSof[ch]),
      .passEof      (passEof[ch]),
      .passedCount  (passedCount[ch]),
      .droppedCount (droppedCount[ch])
    );
  end

  // Back to one stream with a channel tag
  outputMerger merger (
    .CLK        (CLK),
    .reset      (reset),
    .passValid  (passValid),
    .passData   (passData),
    .passSof    (passSof),
    .passEof    (passEof),
    .outValid   (outValid),
    .outChannel (outChannel),
    .outData    (outData),
    .outSof     (outSof),
    .outEof     (outEof)
  );

  // Counter readback
  statReader reader (
    .CLK          (CLK),
    .reset        (reset),
    .statRead     (statRead),
    .statAddr     (statAddr),
    .passedCount  (passedCount),
    .droppedCount (droppedCount),
    .statValid    (statValid),
    .statData     (statData)
  );

endmodule

/* testbench/discardStatTb.sv */
`timescale 1ns/1ps

module discardStatTb;

  logic CLK;
  logic reset;
  discardPkg::frameWord inData;
  logic inValid;
  logic inSof;
  logic inEof;
  logic [discardPkg::CHANNEL_COUNT-1:0] creditReturn;
  logic outValid;
  logic [discardPkg::CHANNEL_BITS-1:0] outChannel;
  discardPkg::frameWord outData;
  logic outSof;
  logic outEof;
  logic statRead;
  logic [discardPkg::STAT_ADDR_BITS-1:0] statAddr;
  logic statValid;
  logic [discardPkg::COUNTER_BITS-1:0] statData;

  // Reference model of credits and counters
  int credit [discardPkg::CHANNEL_COUNT];
  logic [discardPkg::COUNTER_BITS-1:0] passedModel [discardPkg::CHANNEL_COUNT];
  logic [discardPkg::COUNTER_BITS-1:0] droppedModel [discardPkg::CHANNEL_COUNT];
  // Cycles at which passed words give their space back, sorted per channel
  int returnDue [discardPkg::CHANNEL_COUNT][$];
  int lastDue [discardPkg::CHANNEL_COUNT];
  logic holdReturn [discardPkg::CHANNEL_COUNT];
  int cycleNow;
  logic [discardPkg::CHANNEL_BITS-1:0] frameChan;
  logic keepFrame;
  int othersBefore;
  int othersAfter;
  // Expected output of the word driven this cycle
  logic expValidNow;
  logic [discardPkg::CHANNEL_BITS+discardPkg::WORD_BITS+1:0] expWordNow;
  // Expected output pipeline, stage n is n cycles after the input cycle
  logic expValid [1:3];
  logic [discardPkg::CHANNEL_BITS+discardPkg::WORD_BITS+1:0] expWord [1:3];
  // Expected read response of the strobe driven this cycle
  logic statExpValidNow;
  logic [discardPkg::COUNTER_BITS-1:0] statExpDataNow;
  // Expected read response one cycle after the strobe
  logic statExpValid;
  logic [discardPkg::COUNTER_BITS-1:0] statExpData;

  discardStat dut (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Expected values age with the DUT pipeline
  always @(posedge CLK) begin
    for (int s = 3; s > 1; s--) begin
      expValid[s] <= expValid[s-1];
      expWord[s]  <= expWord[s-1];
    end
    expValid[1]  <= expValidNow;
    expWord[1]   <= expWordNow;
    statExpValid <= statExpValidNow;
    statExpData  <= statExpDataNow;
  end

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  assert property (@(posedge CLK) disable iff (reset) outValid == expValid[3])
    else stopOnError($sformatf("** Error at %0t: outValid expected %b, got %b",
                               $time, $sampled(expValid[3]), $sampled(outValid)));
  assert property (@(posedge CLK) disable iff (reset)
                   expValid[3] |-> {outChannel, outSof, outEof, outData.raw} == expWord[3])
    else stopOnError($sformatf(
      "** Error at %0t: {outChannel,outSof,outEof,outData} expected %h, got %h",
      $time, $sampled(expWord[3]),
      $sampled({outChannel, outSof, outEof, outData.raw})));
  assert property (@(posedge CLK) disable iff (reset) statValid == statExpValid)
    else stopOnError($sformatf("** Error at %0t: statValid expected %b, got %b",
                               $time, $sampled(statExpValid), $sampled(statValid)));
  assert property (@(posedge CLK) disable iff (reset)
                   statExpValid |-> statData == statExpData)
    else stopOnError($sformatf("** Error at %0t: statData expected %0d, got %0d",
                               $time, $sampled(statExpData), $sampled(statData)));

  // ------------------------------
  // Stimulus and model
  // ------------------------------
  // One cycle of inputs, model updated in the same step
  task automatic driveCycle(input logic valid, input logic [31:0] word, input logic sof,
                            input logic eof, input logic rd, input logic [2:0] addr);
    int len;
    int due;
    @(posedge CLK);
    #1;
    cycleNow++;
    // Returns of this cycle count for a header driven now
    for (int c = 0; c < discardPkg::CHANNEL_COUNT; c++) begin
      creditReturn[c] = 1'b0;
      if (!holdReturn[c] && returnDue[c].size() > 0 && returnDue[c][0] <= cycleNow) begin
        void'(returnDue[c].pop_front());
        creditReturn[c] = 1'b1;
        credit[c]++;
      end
    end
    if (valid && sof) begin
      frameChan = word[discardPkg::WORD_BITS-1 -: discardPkg::CHANNEL_BITS];
      len = word[discardPkg::LENGTH_BITS-1:0];
      keepFrame = credit[frameChan] >= len;
      if (keepFrame) begin
        credit[frameChan] -= len;
        passedModel[frameChan]++;
      end else begin
        droppedModel[frameChan]++;
      end
    end
    // Downstream frees each word a few cycles after it leaves the DUT
    if (valid && keepFrame) begin
      due = cycleNow + 3 + $urandom_range(1, 8);
      if (due <= lastDue[frameChan]) begin
        due = lastDue[frameChan] + 1;
      end
      lastDue[frameChan] = due;
      returnDue[frameChan].push_back(due);
    end
    expValidNow = valid && keepFrame;
    expWordNow = {frameChan, sof, eof, word};
    statExpValidNow = rd;
    statExpDataNow = addr[0] ? droppedModel[addr[2:1]] : passedModel[addr[2:1]];
    inValid = valid;
    inData.raw = word;
    inSof = sof;
    inEof = eof;
    statRead = rd;
    statAddr = addr;
  endtask

  task automatic idleCycle();
    driveCycle(1'b0, $urandom, 1'b0, 1'b0, 1'b0, 3'd0);
  endtask

  task automatic sendFrame(input int ch, input int len, input int gap);
    logic [31:0] word;
    for (int i = 0; i < len; i++) begin
      word = $urandom;
      if (i == 0) begin
        // Header with random reserved bits
        word[discardPkg::WORD_BITS-1 -: discardPkg::CHANNEL_BITS] =
          ch[discardPkg::CHANNEL_BITS-1:0];
        word[discardPkg::LENGTH_BITS-1:0] = len[discardPkg::LENGTH_BITS-1:0];
      end
      driveCycle(1'b1, word, i == 0, i == len - 1, 1'b0, 3'd0);
    end
    repeat (gap) idleCycle();
  endtask

  // Back-to-back reads of every counter
  task automatic readAllCounters();
    for (int a = 0; a < 2 * discardPkg::CHANNEL_COUNT; a++) begin
      driveCycle(1'b0, $urandom, 1'b0, 1'b0, 1'b1, a[2:0]);
    end
    repeat (2) idleCycle();
  endtask

  task automatic drainReturns();
    int waited;
    int pending;
    waited = 0;
    pending = 1;
    while (pending > 0) begin
      pending = 0;
      for (int c = 0; c < discardPkg::CHANNEL_COUNT; c++) begin
        pending += returnDue[c].size();
      end
      if (waited > 300) begin
        stopOnError("credit returns still pending after the drain timeout");
      end
      idleCycle();
      waited++;
    end
    repeat (3) idleCycle();
  endtask

  initial begin
    void'($urandom(32'h2214_d3c3));
    reset = 1'b1;
    inData = '0;
    inValid = 1'b0;
    inSof = 1'b0;
    inEof = 1'b0;
    creditReturn = '0;
    statRead = 1'b0;
    statAddr = '0;
    cycleNow = 0;
    frameChan = '0;
    keepFrame = 1'b0;
    expValidNow = 1'b0;
    expWordNow = '0;
    statExpValidNow = 1'b0;
    statExpDataNow = '0;
    for (int c = 0; c < discardPkg::CHANNEL_COUNT; c++) begin
      credit[c] = discardPkg::CREDIT_MAX;
      passedModel[c] = '0;
      droppedModel[c] = '0;
      lastDue[c] = 0;
      holdReturn[c] = 1'b0;
    end
    repeat (5) idleCycle();
    reset = 1'b0;
    readAllCounters();
    // Random mixed traffic
    repeat (60) sendFrame($urandom_range(0, 3), $urandom_range(1, 24), $urandom_range(0, 3));
    drainReturns();
    readAllCounters();
    // Oversized frames always drop, a full-buffer frame just fits
    for (int c = 0; c < discardPkg::CHANNEL_COUNT; c++) begin
      sendFrame(c, discardPkg::CREDIT_MAX + 1 + $urandom_range(0, 20), 1);
      sendFrame(c, discardPkg::CREDIT_MAX, 1);
    end
    drainReturns();
    // Channel 0 starved while the others keep running
    othersBefore = droppedModel[1] + droppedModel[2] + droppedModel[3];
    holdReturn[0] = 1'b1;
    repeat (10) begin
      sendFrame(0, 16, 0);
      sendFrame($urandom_range(1, 3), $urandom_range(1, 12), 1);
    end
    othersAfter = droppedModel[1] + droppedModel[2] + droppedModel[3];
    assert (credit[0] < 16 && othersAfter == othersBefore)
      else stopOnError("starvation phase did not starve channel 0 alone");
    holdReturn[0] = 1'b0;
    drainReturns();
    // Restored space lets the same frames pass again
    repeat (4) sendFrame(0, 16, 0);
    drainReturns();
    readAllCounters();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* tb.f */
rtl/discardPkg.sv
rtl/channelSplitter.sv
rtl/discardChannel.sv
rtl/outputMerger.sv
rtl/statReader.sv
rtl/discardStat.sv
testbench/discardStatTb.sv
